// ==== command_proc.f ====
+incdir+src
src/command_proc_pkg.sv
src/stream_fifo.sv
src/cmd_reg_bank.sv
src/cmd_parser.sv
src/rsp_framer.sv
src/command_top.sv
test/command_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run into sim.log, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f command_proc.f \
    --top-module command_top_tb -Mdir obj_dir -o command_top_sim \
    && ./obj_dir/command_top_sim > sim.log 2>&1 \
    || { echo "simulation build or run failed"; exit 1; }
cat sim.log
grep -q "^Verification passed$" sim.log && exit 0 || exit 1

// ==== src/cmd_parser.sv ====
`timescale 1ns/100ps

`include "command_proc_settings.svh"

module cmd_parser (
    input  logic                           clk,
    input  logic                           rst_n,
    // words from the rx fifo
    input  logic                           beat_valid,
    output logic                           beat_ready,
    input  command_proc_pkg::rx_beat_t     beat,
    // register bank
    output logic                           wr_en,
    output logic [`CMD_REG_ADDR_W-1:0]     wr_addr,
    output logic [`CMD_DATA_W-1:0]         wr_data,
    output logic [`CMD_REG_ADDR_W-1:0]     rd_addr,
    input  logic [`CMD_DATA_W-1:0]         rd_data,
    // records into the response fifo
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output command_proc_pkg::rsp_t         rsp
);

    // bank size at full word width, for the range check
    localparam logic [`CMD_DATA_W-1:0] NUM_REGS_W = `CMD_NUM_REGS;

    // which word of the packet is expected next
    typedef enum logic [2:0] {
        S_CSN,
        S_CODE,
        S_REG,
        S_DATA,
        S_DISCARD
    } state_e;

    state_e                         state;
    state_e                         next_state;
    logic                           accept;
    logic                           push_needed;
    logic                           code_known;
    logic                           has_data;
    command_proc_pkg::rsp_status_e  status;
    logic [`CMD_DATA_W-1:0]         csn_q;
    command_proc_pkg::cmd_code_e    code_q;
    logic [`CMD_REG_ADDR_W-1:0]     reg_q;

    ////////////////////
    // decode of the current word
    ////////////////////

    assign code_known = (beat.data == command_proc_pkg::cmd_rd_reg) ||
                        (beat.data == command_proc_pkg::cmd_wr_reg);

    // status is settled at the word that ends the command
    always_comb begin
        push_needed = 1'b0;
        has_data    = 1'b0;
        status      = command_proc_pkg::st_ok;
        case (state)
            S_CSN: begin
                // packet was just the csn
                if (beat.last) begin
                    push_needed = 1'b1;
                    status      = command_proc_pkg::st_short;
                end
            end
            S_CODE: begin
                if (!code_known) begin
                    push_needed = 1'b1;
                    status      = command_proc_pkg::st_bad_code;
                end else if (beat.last) begin
                    push_needed = 1'b1;
                    status      = command_proc_pkg::st_short;
                end
            end
            S_REG: begin
                // range check covers the whole word, not just the index bits
                if (beat.data >= NUM_REGS_W) begin
                    push_needed = 1'b1;
                    status      = command_proc_pkg::st_bad_reg;
                end else if (code_q == command_proc_pkg::cmd_rd_reg) begin
                    push_needed = 1'b1;
                    has_data    = 1'b1;
                end else if (beat.last) begin
                    // write with no data word
                    push_needed = 1'b1;
                    status      = command_proc_pkg::st_short;
                end
            end
            S_DATA: begin
                push_needed = 1'b1;
            end
            default: begin
                push_needed = 1'b0;
            end
        endcase
    end

    // a word that pushes a record waits for fifo room
    assign beat_ready = !push_needed || rsp_ready;
    assign accept     = beat_valid && beat_ready;
    assign rsp_valid  = beat_valid && push_needed;

    always_comb begin
        if (push_needed) begin
            // leftovers after the deciding word are dropped
            next_state = beat.last ? S_CSN : S_DISCARD;
        end else begin
            case (state)
                S_CSN:   next_state = S_CODE;
                S_CODE:  next_state = S_REG;
                S_REG:   next_state = S_DATA;
                default: next_state = beat.last ? S_CSN : S_DISCARD;
            endcase
        end
    end

    ////////////////////
    // state and latched fields
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_CSN;
        end else if (accept) begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (state)
                S_CSN:   csn_q  <= beat.data;
                S_CODE:  code_q <= command_proc_pkg::cmd_code_e'(beat.data);
                S_REG:   reg_q  <= beat.data[`CMD_REG_ADDR_W-1:0];
                default: ;
            endcase
        end
    end

    ////////////////////
    // bank access and record
    ////////////////////

    // write lands on the edge that takes the data word
    assign wr_en   = accept && (state == S_DATA);
    assign wr_addr = reg_q;
    assign wr_data = beat.data;
    // read index comes straight off the register-number word
    assign rd_addr = beat.data[`CMD_REG_ADDR_W-1:0];

    // csn is still on the wire when the packet ends at word one
    assign rsp.csn      = (state == S_CSN) ? beat.data : csn_q;
    assign rsp.status   = status;
    assign rsp.data     = has_data ? rd_data : '0;
    assign rsp.has_data = has_data;

endmodule

// ==== src/cmd_reg_bank.sv ====
`timescale 1ns/100ps

`include "command_proc_settings.svh"

module cmd_reg_bank (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_en,
    input  logic [`CMD_REG_ADDR_W-1:0] wr_addr,
    input  logic [`CMD_DATA_W-1:0]     wr_data,
    input  logic [`CMD_REG_ADDR_W-1:0] rd_addr,
    output logic [`CMD_DATA_W-1:0]     rd_data
);

    logic [`CMD_DATA_W-1:0] regs [`CMD_NUM_REGS];

    ////////////////////
    // write port
    ////////////////////

    // all registers come up as zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CMD_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // combinational, the parser samples it the cycle the index arrives
    assign rd_data = regs[rd_addr];

endmodule

// ==== src/command_proc_pkg.sv ====
`include "command_proc_settings.svh"

package command_proc_pkg;

    ////////////////////
    // command and status codes
    ////////////////////

    // second word of a command packet
    typedef enum logic [31:0] {
        cmd_rd_reg = 32'd2,
        cmd_wr_reg = 32'd3
    } cmd_code_e;

    // second word of a response packet
    typedef enum logic [31:0] {
        st_ok       = 32'd0,
        st_bad_code = 32'd1,
        st_bad_reg  = 32'd2,
        st_short    = 32'd3
    } rsp_status_e;

    ////////////////////
    // records carried by the fifos
    ////////////////////

    // one word off the link, tlast kept alongside
    typedef struct packed {
        logic [`CMD_DATA_W-1:0] data;
        logic                   last;
    } rx_beat_t;

    // one response, framed later into 2 or 3 words
    typedef struct packed {
        logic [`CMD_DATA_W-1:0] csn;
        rsp_status_e            status;
        logic [`CMD_DATA_W-1:0] data;
        // set only for a good read
        logic                   has_data;
    } rsp_t;

endpackage

// ==== src/command_proc_settings.svh ====
`ifndef COMMAND_PROC_SETTINGS_SVH
`define COMMAND_PROC_SETTINGS_SVH

////////////////////
// link and register sizes
////////////////////

// stream word width, also the register width
`define CMD_DATA_W 32

// registers in the bank
`define CMD_NUM_REGS 16

// index bits into the bank
`define CMD_REG_ADDR_W 4

// fifo depths in entries
`define CMD_RX_DEPTH 4
`define CMD_RSP_DEPTH 4

`endif

// ==== src/command_top.sv ====
`timescale 1ns/100ps

`include "command_proc_settings.svh"

module command_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // rx link stream
    input  logic [`CMD_DATA_W-1:0] rx_data,
    input  logic                   rx_tvalid,
    input  logic                   rx_tlast,
    output logic                   rx_tready,
    // tx link stream
    output logic [`CMD_DATA_W-1:0] tx_data,
    output logic                   tx_tvalid,
    output logic                   tx_tlast,
    input  logic                   tx_tready
);

    ////////////////////
    // internal wires
    ////////////////////

    command_proc_pkg::rx_beat_t    rx_beat;
    command_proc_pkg::rx_beat_t    beat;
    logic                          beat_valid;
    logic                          beat_ready;

    logic                          wr_en;
    logic [`CMD_REG_ADDR_W-1:0]    wr_addr;
    logic [`CMD_DATA_W-1:0]        wr_data;
    logic [`CMD_REG_ADDR_W-1:0]    rd_addr;
    logic [`CMD_DATA_W-1:0]        rd_data;

    command_proc_pkg::rsp_t        rsp_in;
    logic                          rsp_in_valid;
    logic                          rsp_in_ready;
    command_proc_pkg::rsp_t        rsp_out;
    logic                          rsp_out_valid;
    logic                          rsp_out_ready;

    // link word and its tlast stored together
    assign rx_beat.data = rx_data;
    assign rx_beat.last = rx_tlast;

    ////////////////////
    // rx side
    ////////////////////

    stream_fifo #(
        .payload_t (command_proc_pkg::rx_beat_t),
        .DEPTH     (`CMD_RX_DEPTH)
    ) rx_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (rx_tvalid),
        .push_ready (rx_tready),
        .push_data  (rx_beat),
        .pop_valid  (beat_valid),
        .pop_ready  (beat_ready),
        .pop_data   (beat)
    );

    cmd_parser i_cmd_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .beat       (beat),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rsp_valid  (rsp_in_valid),
        .rsp_ready  (rsp_in_ready),
        .rsp        (rsp_in)
    );

    cmd_reg_bank i_cmd_reg_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ////////////////////
    // tx side
    ////////////////////

    stream_fifo #(
        .payload_t (command_proc_pkg::rsp_t),
        .DEPTH     (`CMD_RSP_DEPTH)
    ) rsp_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (rsp_in_valid),
        .push_ready (rsp_in_ready),
        .push_data  (rsp_in),
        .pop_valid  (rsp_out_valid),
        .pop_ready  (rsp_out_ready),
        .pop_data   (rsp_out)
    );

    rsp_framer i_rsp_framer (
        .clk       (clk),
        .rst_n     (rst_n),
        .rsp_valid (rsp_out_valid),
        .rsp_ready (rsp_out_ready),
        .rsp       (rsp_out),
        .tx_data   (tx_data),
        .tx_tvalid (tx_tvalid),
        .tx_tlast  (tx_tlast),
        .tx_tready (tx_tready)
    );

endmodule

// ==== src/rsp_framer.sv ====
`timescale 1ns/100ps

`include "command_proc_settings.svh"

module rsp_framer (
    input  logic                       clk,
    input  logic                       rst_n,
    // records from the response fifo
    input  logic                       rsp_valid,
    output logic                       rsp_ready,
    input  command_proc_pkg::rsp_t     rsp,
    // tx link stream
    output logic [`CMD_DATA_W-1:0]     tx_data,
    output logic                       tx_tvalid,
    output logic                       tx_tlast,
    input  logic                       tx_tready
);

    // word position inside the current response
    logic [1:0] idx;
    logic       last_word;
    logic       xfer;

    ////////////////////
    // word select
    ////////////////////

    // record stays at the fifo head until its last word goes out
    always_comb begin
        case (idx)
            2'd0:    tx_data = rsp.csn;
            2'd1:    tx_data = rsp.status;
            2'd2:    tx_data = rsp.data;
            default: tx_data = '0;
        endcase
    end

    // two words without data, three with
    assign last_word = ((idx == 2'd1) && !rsp.has_data) || (idx == 2'd2);

    ////////////////////
    // handshake
    ////////////////////

    // low out of reset since the fifo starts empty
    assign tx_tvalid = rsp_valid;
    assign tx_tlast  = last_word;
    assign xfer      = tx_tvalid && tx_tready;
    // pop only with the final word
    assign rsp_ready = tx_tready && last_word;

    ////////////////////
    // word index
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx <= 2'd0;
        end else if (xfer) begin
            if (last_word) begin
                idx <= 2'd0;
            end else begin
                idx <= idx + 2'd1;
            end
        end
    end

endmodule

// ==== src/stream_fifo.sv ====
`timescale 1ns/100ps

module stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push_valid,
    output logic     push_ready,
    input  payload_t push_data,
    output logic     pop_valid,
    input  logic     pop_ready,
    output payload_t pop_data
);

    // pointer and count widths
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t       mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           do_push;
    logic           do_pop;

    ////////////////////
    // handshake
    ////////////////////

    // ready only while there is room
    assign push_ready = (count != CW'(DEPTH));
    // valid whenever something is stored
    assign pop_valid  = (count != '0);
    // head of the queue, read straight from storage
    assign pop_data   = mem[rd_ptr];

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    ////////////////////
    // pointers and occupancy
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // wrap explicitly, depth need not be a power of two
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== test/command_top_tb.sv ====
`timescale 1ns/100ps

module command_top_tb;

    localparam logic [31:0] SEED_INIT   = 32'hc8a114b7;
    localparam int          HALF_PERIOD = 20;
    // all commands issued below, phases 1 to 6
    localparam int          NUM_CMDS    = 43;
    localparam int          TIMEOUT     = 40 * NUM_CMDS + 200;
    localparam logic [31:0] CODE_RD     = 32'd2;
    localparam logic [31:0] CODE_WR     = 32'd3;
    localparam logic [31:0] ST_OK       = 32'd0;
    localparam logic [31:0] ST_BAD_CODE = 32'd1;
    localparam logic [31:0] ST_BAD_REG  = 32'd2;
    localparam logic [31:0] ST_SHORT    = 32'd3;

    logic        clk;
    logic        rst_n;
    logic [31:0] rx_data;
    logic        rx_tvalid;
    logic        rx_tlast;
    logic        rx_tready;
    logic [31:0] tx_data;
    logic        tx_tvalid;
    logic        tx_tlast;
    logic        tx_tready;

    integer      seed;
    logic [31:0] roll;
    logic [31:0] cmd_roll;
    logic [31:0] cmd_data;
    logic        rx_gap;
    int          tick = 0;
    int          hold_until;
    int          cycles;
    logic [31:0] model_regs [16];
    logic [31:0] pkt [8];
    logic [31:0] next_csn;
    // expected tx words in order, with their tlast
    logic [31:0] exp_words [$];
    logic        exp_last [$];
    logic [31:0] exp_d;
    logic        exp_l;
    logic        saw_rx_stall;
    int          errors;
    int          timeouts;

    command_top i_command_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_tvalid (rx_tvalid),
        .rx_tlast  (rx_tlast),
        .rx_tready (rx_tready),
        .tx_data   (tx_data),
        .tx_tvalid (tx_tvalid),
        .tx_tlast  (tx_tlast),
        .tx_tready (tx_tready)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    ////////////////////
    // random back-pressure and rx gaps
    ////////////////////

    // one process draws all per-cycle randoms
    always @(posedge clk) begin
        roll = $random(seed);
        tick <= tick + 1;
        rx_gap <= (roll[1:0] == 2'b00);
        // forced stall window for the fill test
        if (tick < hold_until) begin
            tx_tready <= 1'b0;
        end else begin
            tx_tready <= (roll[3:2] != 2'b00);
        end
    end

    ////////////////////
    // link driver and reference model
    ////////////////////

    // returns at the negedge before the edge that takes the word
    task automatic drive_word(input logic [31:0] d, input logic l);
        @(posedge clk);
        while (rx_gap) begin
            rx_tvalid <= 1'b0;
            @(posedge clk);
        end
        rx_tvalid <= 1'b1;
        rx_data   <= d;
        rx_tlast  <= l;
        @(negedge clk);
        while (!rx_tready) begin
            @(negedge clk);
        end
    endtask

    task automatic send_packet(input int len);
        logic [31:0] status;
        logic [31:0] rdata;
        logic        with_data;
        pkt[0]    = next_csn;
        next_csn  = next_csn + 32'd1;
        with_data = 1'b0;
        rdata     = 32'd0;
        // first rule that fails decides the status
        if (len < 2) begin
            status = ST_SHORT;
        end else if (pkt[1] != CODE_RD && pkt[1] != CODE_WR) begin
            status = ST_BAD_CODE;
        end else if (len < 3) begin
            status = ST_SHORT;
        end else if (pkt[2] >= 32'd16) begin
            status = ST_BAD_REG;
        end else if (pkt[1] == CODE_RD) begin
            status    = ST_OK;
            with_data = 1'b1;
            rdata     = model_regs[pkt[2][3:0]];
        end else if (len < 4) begin
            status = ST_SHORT;
        end else begin
            status = ST_OK;
            model_regs[pkt[2][3:0]] = pkt[3];
        end
        exp_words.push_back(pkt[0]);
        exp_last.push_back(1'b0);
        exp_words.push_back(status);
        exp_last.push_back(!with_data);
        if (with_data) begin
            exp_words.push_back(rdata);
            exp_last.push_back(1'b1);
        end
        for (int i = 0; i < len; i++) begin
            drive_word(pkt[i], i == len - 1);
        end
    endtask

    task automatic write_reg(input logic [31:0] r, input logic [31:0] d);
        pkt[1] = CODE_WR;
        pkt[2] = r;
        pkt[3] = d;
        send_packet(4);
    endtask

    task automatic read_reg(input logic [31:0] r);
        pkt[1] = CODE_RD;
        pkt[2] = r;
        send_packet(3);
    endtask

    task automatic finish_run;
        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    ////////////////////
    // tx monitor
    ////////////////////

    // sample at negedge, the transfer lands on the next posedge
    always @(negedge clk) begin
        if (rst_n && !rx_tready) begin
            saw_rx_stall = 1'b1;
        end
        if (rst_n && tx_tvalid && tx_tready) begin
            assert (exp_words.size() != 0) else begin
                errors++;
                $display("response word arrived on tx with no command outstanding");
            end
            if (exp_words.size() != 0) begin
                exp_d = exp_words.pop_front();
                exp_l = exp_last.pop_front();
                assert (tx_data === exp_d) else begin
                    errors++;
                    $display("error tx_data got %h expected %h", tx_data, exp_d);
                end
                assert (tx_tlast === exp_l) else begin
                    errors++;
                    $display("error tx_tlast got %h expected %h", tx_tlast, exp_l);
                end
            end
        end
    end

    // cycle limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        timeouts++;
        $display("timeout after %0d cycles, responses did not complete", cycles);
        finish_run();
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        seed         = SEED_INIT;
        rst_n        = 1'b0;
        rx_data      = 32'd0;
        rx_tvalid    = 1'b0;
        rx_tlast     = 1'b0;
        tx_tready    = 1'b0;
        rx_gap       = 1'b0;
        hold_until   = 0;
        next_csn     = 32'h0000_0100;
        saw_rx_stall = 1'b0;
        errors       = 0;
        timeouts     = 0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (tx_tvalid === 1'b0) else begin
            errors++;
            $display("error tx_tvalid got %h expected %h", tx_tvalid, 1'b0);
        end
        assert (rx_tready === 1'b1) else begin
            errors++;
            $display("error rx_tready got %h expected %h", rx_tready, 1'b1);
        end
        // write then read back
        write_reg(32'd3, 32'ha5a5_1234);
        read_reg(32'd3);
        // both ends of the bank
        write_reg(32'd0, 32'h0bad_cafe);
        write_reg(32'd15, 32'h7777_0001);
        read_reg(32'd15);
        read_reg(32'd0);
        // unknown codes, long and short, then a clean packet
        pkt[1] = 32'd7;
        pkt[2] = 32'd3;
        pkt[3] = 32'hdead_beef;
        send_packet(4);
        pkt[1] = 32'd0;
        send_packet(2);
        read_reg(32'd3);
        // out of range, low index bits alias a real register
        write_reg(32'd16, 32'h1111_1111);
        write_reg(32'h0000_0013, 32'h2222_2222);
        read_reg(32'hffff_fff3);
        read_reg(32'd3);
        read_reg(32'd0);
        // early tlast at each position
        send_packet(1);
        pkt[1] = CODE_WR;
        send_packet(2);
        pkt[2] = 32'd5;
        send_packet(3);
        // write with trailing words is still ok
        pkt[3] = 32'h5555_aaaa;
        pkt[4] = 32'h0000_0009;
        pkt[5] = 32'hffff_ffff;
        send_packet(6);
        pkt[1] = CODE_RD;
        send_packet(4);
        // back-to-back traffic against a stalled tx
        hold_until = tick + 60;
        for (int k = 0; k < 24; k++) begin
            cmd_roll = $random(seed);
            cmd_data = $random(seed);
            if (cmd_roll[0]) begin
                write_reg({28'd0, cmd_roll[7:4]}, cmd_data);
            end else begin
                read_reg({28'd0, cmd_roll[7:4]});
            end
        end
        @(posedge clk);
        rx_tvalid <= 1'b0;
        while (exp_words.size() != 0) begin
            @(posedge clk);
        end
        // catch any stray trailing word
        repeat (10) @(posedge clk);
        assert (saw_rx_stall) else begin
            errors++;
            $display("rx_tready never fell under tx back-pressure");
        end
        finish_run();
    end

endmodule
